/* tb.f */
hdl/dma_pkg.sv
hdl/dma_job_fifo.sv
hdl/dma_req_front.sv
hdl/dma_read_engine.sv
hdl/dma_write_engine.sv
hdl/dma_rsp_unit.sv
hdl/dma_backend_top.sv
tests/tb_clk_gen.sv
tests/dma_mem_model.sv
tests/dma_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the copy engine testbench with Verilator

LOG=sim.log

verilator --binary --timing --top-module dma_tb -f tb.f -Mdir obj_dir -o dma_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dma_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Test failed" "$LOG"; then
    echo "Simulation FAILED"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi

echo "Simulation PASSED"
exit 0

/* tests/dma_tb.sv */
// Self-checking testbench of the word copy engine
// Applies a request table, checks responses, copied memory and idle state
`timescale 1ns/1ps

module dma_tb;

    import dma_pkg::*;

    localparam int NUM_TESTS    = 12;
    localparam int MEM_WORDS    = 2 ** ADDR_W;
    localparam int DRAIN_CYCLES = 20;

    // One table row holds a request and the response it must get
    typedef struct packed {
        copy_req_t req;
        copy_rsp_t exp;
    } test_vec_t;

    logic        clk;
    logic        rst;
    copy_req_t   req;
    logic        req_valid;
    logic        req_ready;
    copy_rsp_t   rsp;
    logic        rsp_valid;
    logic        rsp_ready;
    mem_rd_req_t rd_req;
    logic        rd_valid;
    logic        rd_ready;
    data_t       rd_data;
    logic        rd_data_valid;
    mem_wr_req_t wr_req;
    logic        wr_valid;
    logic        wr_ready;
    busy_t       busy;

    test_vec_t tests [NUM_TESTS];
    data_t     ref_mem [MEM_WORDS];
    int        num_loaded = 0;
    int        req_idx    = 0;
    int        rsp_cnt    = 0;
    int        wr_cnt     = 0;
    int        seed       = 32'hcfc5;

    tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(5)) clk_gen (
        .clk_o ( clk ),
        .rst_o ( rst )
    );

    dma_mem_model #(.SEED(32'hcfc5)) mem_model (
        .clk_i           ( clk           ),
        .rst_i           ( rst           ),
        .rd_req_i        ( rd_req        ),
        .rd_valid_i      ( rd_valid      ),
        .rd_ready_o      ( rd_ready      ),
        .rd_data_o       ( rd_data       ),
        .rd_data_valid_o ( rd_data_valid ),
        .wr_req_i        ( wr_req        ),
        .wr_valid_i      ( wr_valid      ),
        .wr_ready_o      ( wr_ready      )
    );

    dma_backend_top UUT (
        .clk_i           ( clk           ),
        .rst_i           ( rst           ),
        .req_i           ( req           ),
        .req_valid_i     ( req_valid     ),
        .req_ready_o     ( req_ready     ),
        .rsp_o           ( rsp           ),
        .rsp_valid_o     ( rsp_valid     ),
        .rsp_ready_i     ( rsp_ready     ),
        .rd_req_o        ( rd_req        ),
        .rd_valid_o      ( rd_valid      ),
        .rd_ready_i      ( rd_ready      ),
        .rd_data_i       ( rd_data       ),
        .rd_data_valid_i ( rd_data_valid ),
        .wr_req_o        ( wr_req        ),
        .wr_valid_o      ( wr_valid      ),
        .wr_ready_i      ( wr_ready      ),
        .busy_o          ( busy          )
    );

    // --------------------
    // Table and helpers
    // --------------------
    function automatic void add_test(input addr_w_t src, input addr_w_t dst, input len_t len,
                                     input logic last, input logic exp_err, input logic exp_last);
        tests[num_loaded].req = '{src_addr: src, dst_addr: dst, length: len, last: last};
        tests[num_loaded].exp = '{error: exp_err, last: exp_last};
        num_loaded++;
    endfunction

    // Source and destination regions never overlap
    // Zero length rows expect an error response
    function automatic void load_table();
        add_test(16'h0100, 16'h1000, 8'd1,   1'b0, 1'b0, 1'b0);
        add_test(16'h0110, 16'h1010, 8'd4,   1'b0, 1'b0, 1'b0);
        add_test(16'h0120, 16'h1020, 8'd0,   1'b1, 1'b1, 1'b1);
        add_test(16'h0130, 16'h1030, 8'd7,   1'b1, 1'b0, 1'b1);
        add_test(16'h0140, 16'h1040, 8'd0,   1'b0, 1'b1, 1'b0);
        add_test(16'h0150, 16'h1050, 8'd16,  1'b0, 1'b0, 1'b0);
        add_test(16'h0200, 16'h1100, 8'd33,  1'b1, 1'b0, 1'b1);
        add_test(16'h0300, 16'h1200, 8'd2,   1'b0, 1'b0, 1'b0);
        add_test(16'h0310, 16'h1210, 8'd3,   1'b1, 1'b0, 1'b1);
        add_test(16'h0400, 16'h1300, 8'd255, 1'b1, 1'b0, 1'b1);
        add_test(16'h0600, 16'h1500, 8'd5,   1'b0, 1'b0, 1'b0);
        add_test(16'h0620, 16'h1520, 8'd0,   1'b1, 1'b1, 1'b1);
    endfunction

    function automatic int total_words();
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            sum += int'(tests[i].req.length);
        end
        return sum;
    endfunction

    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first failing check");
    endtask

    // Initial contents with every table copy applied
    task automatic build_reference();
        addr_w_t src;
        addr_w_t dst;
        for (int a = 0; a < MEM_WORDS; a++) begin
            ref_mem[addr_w_t'(a)] = mem_model.mem_q[addr_w_t'(a)];
        end
        for (int i = 0; i < NUM_TESTS; i++) begin
            src = tests[i].req.src_addr;
            dst = tests[i].req.dst_addr;
            for (int k = 0; k < int'(tests[i].req.length); k++) begin
                ref_mem[dst + addr_w_t'(k)] = ref_mem[src + addr_w_t'(k)];
            end
        end
    endtask

    // Whole memory is compared so untouched words are covered too
    task automatic check_memory();
        data_t got;
        data_t exp;
        for (int a = 0; a < MEM_WORDS; a++) begin
            got = mem_model.mem_q[addr_w_t'(a)];
            exp = ref_mem[addr_w_t'(a)];
            assert (got == exp) else begin
                $display("[ERROR] t=%0t mem[0x%04h]: expected %08h, got %08h", $time, a, exp, got);
                stop_on_failure();
            end
        end
    endtask

    // --------------------
    // Monitors
    // --------------------
    always @(posedge clk) begin
        if (!rst && wr_valid && wr_ready) begin
            wr_cnt++;
        end
        if (!rst && rsp_valid && rsp_ready) begin
            assert (rsp_cnt < NUM_TESTS) else begin
                $display("Extra response at %0t after all %0d requests answered", $time, rsp_cnt);
                stop_on_failure();
            end
            assert (rsp.error == tests[rsp_cnt].exp.error) else begin
                $display("[ERROR] t=%0t rsp_o.error (response %0d): expected %0b, got %0b",
                         $time, rsp_cnt, tests[rsp_cnt].exp.error, rsp.error);
                stop_on_failure();
            end
            assert (rsp.last == tests[rsp_cnt].exp.last) else begin
                $display("[ERROR] t=%0t rsp_o.last (response %0d): expected %0b, got %0b",
                         $time, rsp_cnt, tests[rsp_cnt].exp.last, rsp.last);
                stop_on_failure();
            end
            rsp_cnt++;
        end
    end

    // Response consumer stalls at random in the second half
    initial begin
        logic [31:0] rnd;
        rsp_ready = 1'b0;
        forever begin
            @(negedge clk);
            rnd       = $random(seed);
            rsp_ready = (req_idx < NUM_TESTS / 2) | rnd[0];
        end
    end

    // Bound grows with the number of words in the table
    initial begin
        int bound;
        @(negedge clk);
        bound = 400 + 30 * NUM_TESTS + 12 * total_words();
        repeat (bound) @(posedge clk);
        $display("Timeout after %0d cycles, %0d of %0d responses received",
                 bound, rsp_cnt, NUM_TESTS);
        stop_on_failure();
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        req       = '0;
        req_valid = 1'b0;
        load_table();
        @(negedge rst);
        @(negedge clk);

        // Quiet outputs right after reset
        assert (!rsp_valid && !rd_valid && !wr_valid) else begin
            $display("[ERROR] t=%0t valids after reset: expected 000, got %0b%0b%0b",
                     $time, rsp_valid, rd_valid, wr_valid);
            stop_on_failure();
        end
        assert (busy == '0) else begin
            $display("[ERROR] t=%0t busy_o after reset: expected 0000, got %04b", $time, busy);
            stop_on_failure();
        end
        build_reference();

        // Back to back requests with the next one driven right after acceptance
        for (int i = 0; i < NUM_TESTS; i++) begin
            req       = tests[i].req;
            req_valid = 1'b1;
            @(posedge clk);
            while (!req_ready) @(posedge clk);
            req_idx = i + 1;
            @(negedge clk);
        end
        req_valid = 1'b0;
        req       = '0;

        // Extra responses during the drain are caught by the monitor
        while (rsp_cnt < NUM_TESTS) @(negedge clk);
        repeat (DRAIN_CYCLES) @(negedge clk);

        assert (wr_cnt == total_words()) else begin
            $display("[ERROR] t=%0t write count: expected %0d, got %0d",
                     $time, total_words(), wr_cnt);
            stop_on_failure();
        end
        assert (busy == '0) else begin
            $display("[ERROR] t=%0t busy_o: expected 0000, got %04b", $time, busy);
            stop_on_failure();
        end
        check_memory();

        $display("Test completed successfully");
        $finish;
    end

endmodule

/* tests/dma_mem_model.sv */
// Behavioral word memory for the copy engine testbench
// Random port stalls, reads return in issue order after 1 to 3 cycles
`timescale 1ns/1ps

module dma_mem_model #(
    parameter int SEED = 32'hcfc5
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  dma_pkg::mem_rd_req_t rd_req_i,
    input  logic                 rd_valid_i,
    output logic                 rd_ready_o,
    output dma_pkg::data_t       rd_data_o,
    output logic                 rd_data_valid_o,
    input  dma_pkg::mem_wr_req_t wr_req_i,
    input  logic                 wr_valid_i,
    output logic                 wr_ready_o
);

    import dma_pkg::*;

    localparam int MEM_WORDS = 2 ** ADDR_W;

    data_t mem_q [MEM_WORDS];
    // Read returns waiting, with the cycle each one is due
    data_t rd_q [$];
    int    due_q [$];
    int    seed;
    int    cycle;
    int    last_due;

    // Fill pattern, every address bit changes the word
    function automatic data_t fill_word(addr_w_t a);
        return {a ^ 16'hc3a5, ~a};
    endfunction

    initial begin
        int lat;
        int due;
        seed            = SEED;
        cycle           = 0;
        last_due        = 0;
        rd_ready_o      = 1'b0;
        wr_ready_o      = 1'b0;
        rd_data_o       = '0;
        rd_data_valid_o = 1'b0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem_q[addr_w_t'(a)] = fill_word(addr_w_t'(a));
        end
        forever begin
            // --------------------
            // Rising edge: accept
            // --------------------
            @(posedge clk_i);
            if (rst_i) begin
                rd_q.delete();
                due_q.delete();
                cycle    = 0;
                last_due = 0;
            end else begin
                cycle++;
                if (rd_valid_i && rd_ready_o) begin
                    lat = 1 + int'($unsigned($random(seed)) % 3);
                    due = cycle + lat - 1;
                    // Keep issue order, one return per cycle
                    if (due <= last_due) begin
                        due = last_due + 1;
                    end
                    last_due = due;
                    rd_q.push_back(mem_q[rd_req_i]);
                    due_q.push_back(due);
                end
                if (wr_valid_i && wr_ready_o) begin
                    mem_q[wr_req_i.addr] = wr_req_i.data;
                end
            end
            // --------------------
            // Falling edge: drive
            // --------------------
            @(negedge clk_i);
            rd_ready_o = !rst_i && (($random(seed) & 3) != 0);
            wr_ready_o = !rst_i && (($random(seed) & 3) != 0);
            if (due_q.size() != 0 && due_q[0] <= cycle) begin
                rd_data_o       = rd_q.pop_front();
                void'(due_q.pop_front());
                rd_data_valid_o = 1'b1;
            end else begin
                rd_data_valid_o = 1'b0;
            end
        end
    end

endmodule

/* tests/tb_clk_gen.sv */
// Clock and reset source for the copy engine testbench
// Reset is synchronous, active high, released on a falling edge
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    // Free-running clock, starts low
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Held for RST_CYCLES rising edges
    initial begin
        rst_o = 1'b1;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

/* hdl/dma_backend_top.sv */
// Top level of the word copy engine: front end, job queues, data buffer and engines
// Connect the request, response, read and write ports to the surrounding system
`timescale 1ns/1ps

module dma_backend_top (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  dma_pkg::copy_req_t   req_i,
    input  logic                 req_valid_i,
    output logic                 req_ready_o,
    output dma_pkg::copy_rsp_t   rsp_o,
    output logic                 rsp_valid_o,
    input  logic                 rsp_ready_i,
    output dma_pkg::mem_rd_req_t rd_req_o,
    output logic                 rd_valid_o,
    input  logic                 rd_ready_i,
    input  dma_pkg::data_t       rd_data_i,
    input  logic                 rd_data_valid_i,
    output dma_pkg::mem_wr_req_t wr_req_o,
    output logic                 wr_valid_o,
    input  logic                 wr_ready_i,
    output dma_pkg::busy_t       busy_o
);

    import dma_pkg::*;

    // Front end to queues
    rd_job_t  rd_job_in, rd_job_out;
    wr_job_t  wr_job_in, wr_job_out;
    rsp_job_t rsp_job_in, rsp_job_out;
    logic     rd_job_in_valid, rd_job_in_ready, rd_job_out_valid, rd_job_out_ready;
    logic     wr_job_in_valid, wr_job_in_ready, wr_job_out_valid, wr_job_out_ready;
    logic     rsp_job_in_valid, rsp_job_in_ready, rsp_job_out_valid, rsp_job_out_ready;

    // Data buffer between the engines
    data_t    buf_in_data, buf_out_data;
    logic     buf_in_valid, buf_out_valid, buf_out_ready;
    buf_cnt_t buf_space;
    logic     job_done;

    dma_req_front i_front (
        .clk_i           ( clk_i             ),
        .rst_i           ( rst_i             ),
        .req_i           ( req_i             ),
        .req_valid_i     ( req_valid_i       ),
        .req_ready_o     ( req_ready_o       ),
        .rd_job_o        ( rd_job_in         ),
        .rd_job_valid_o  ( rd_job_in_valid   ),
        .rd_job_ready_i  ( rd_job_in_ready   ),
        .wr_job_o        ( wr_job_in         ),
        .wr_job_valid_o  ( wr_job_in_valid   ),
        .wr_job_ready_i  ( wr_job_in_ready   ),
        .rsp_job_o       ( rsp_job_in        ),
        .rsp_job_valid_o ( rsp_job_in_valid  ),
        .rsp_job_ready_i ( rsp_job_in_ready  ),
        .busy_o          ( busy_o.front_busy )
    );

    // --------------------
    // Job queues
    // --------------------
    dma_job_fifo #(.WIDTH($bits(rd_job_t)), .DEPTH(JOB_DEPTH)) i_rd_job_q (
        .clk_i   ( clk_i            ),
        .rst_i   ( rst_i            ),
        .data_i  ( rd_job_in        ),
        .valid_i ( rd_job_in_valid  ),
        .ready_o ( rd_job_in_ready  ),
        .data_o  ( rd_job_out       ),
        .valid_o ( rd_job_out_valid ),
        .ready_i ( rd_job_out_ready ),
        .free_o  (                  )
    );

    dma_job_fifo #(.WIDTH($bits(wr_job_t)), .DEPTH(JOB_DEPTH)) i_wr_job_q (
        .clk_i   ( clk_i            ),
        .rst_i   ( rst_i            ),
        .data_i  ( wr_job_in        ),
        .valid_i ( wr_job_in_valid  ),
        .ready_o ( wr_job_in_ready  ),
        .data_o  ( wr_job_out       ),
        .valid_o ( wr_job_out_valid ),
        .ready_i ( wr_job_out_ready ),
        .free_o  (                  )
    );

    // Flag store that keeps responses in request order
    dma_job_fifo #(.WIDTH($bits(rsp_job_t)), .DEPTH(JOB_DEPTH)) i_rsp_job_q (
        .clk_i   ( clk_i             ),
        .rst_i   ( rst_i             ),
        .data_i  ( rsp_job_in        ),
        .valid_i ( rsp_job_in_valid  ),
        .ready_o ( rsp_job_in_ready  ),
        .data_o  ( rsp_job_out       ),
        .valid_o ( rsp_job_out_valid ),
        .ready_i ( rsp_job_out_ready ),
        .free_o  (                   )
    );

    // --------------------
    // Data path
    // --------------------
    dma_read_engine i_rd_engine (
        .clk_i           ( clk_i            ),
        .rst_i           ( rst_i            ),
        .job_i           ( rd_job_out       ),
        .job_valid_i     ( rd_job_out_valid ),
        .job_ready_o     ( rd_job_out_ready ),
        .rd_req_o        ( rd_req_o         ),
        .rd_valid_o      ( rd_valid_o       ),
        .rd_ready_i      ( rd_ready_i       ),
        .rd_data_i       ( rd_data_i        ),
        .rd_data_valid_i ( rd_data_valid_i  ),
        .buf_data_o      ( buf_in_data      ),
        .buf_valid_o     ( buf_in_valid     ),
        .buf_space_i     ( buf_space        ),
        .busy_o          ( busy_o.rd_busy   )
    );

    // Ready is not looked at, read credit already reserves a slot per word
    dma_job_fifo #(.WIDTH(DATA_W), .DEPTH(BUF_DEPTH)) i_data_buf (
        .clk_i   ( clk_i         ),
        .rst_i   ( rst_i         ),
        .data_i  ( buf_in_data   ),
        .valid_i ( buf_in_valid  ),
        .ready_o (               ),
        .data_o  ( buf_out_data  ),
        .valid_o ( buf_out_valid ),
        .ready_i ( buf_out_ready ),
        .free_o  ( buf_space     )
    );

    dma_write_engine i_wr_engine (
        .clk_i       ( clk_i            ),
        .rst_i       ( rst_i            ),
        .job_i       ( wr_job_out       ),
        .job_valid_i ( wr_job_out_valid ),
        .job_ready_o ( wr_job_out_ready ),
        .buf_data_i  ( buf_out_data     ),
        .buf_valid_i ( buf_out_valid    ),
        .buf_ready_o ( buf_out_ready    ),
        .wr_req_o    ( wr_req_o         ),
        .wr_valid_o  ( wr_valid_o       ),
        .wr_ready_i  ( wr_ready_i       ),
        .job_done_o  ( job_done         ),
        .busy_o      ( busy_o.wr_busy   )
    );

    dma_rsp_unit i_rsp_unit (
        .clk_i           ( clk_i             ),
        .rst_i           ( rst_i             ),
        .rsp_job_i       ( rsp_job_out       ),
        .rsp_job_valid_i ( rsp_job_out_valid ),
        .rsp_job_ready_o ( rsp_job_out_ready ),
        .job_done_i      ( job_done          ),
        .rsp_o           ( rsp_o             ),
        .rsp_valid_o     ( rsp_valid_o       ),
        .rsp_ready_i     ( rsp_ready_i       ),
        .busy_o          ( busy_o.rsp_busy   )
    );

endmodule

/* hdl/dma_rsp_unit.sv */
// Response unit: releases one response per request in request order
// Error jobs go out at once, copy jobs wait for a matching completion
`timescale 1ns/1ps

module dma_rsp_unit (
    input  logic                clk_i,
    input  logic                rst_i,
    input  dma_pkg::rsp_job_t   rsp_job_i,
    input  logic                rsp_job_valid_i,
    output logic                rsp_job_ready_o,
    input  logic                job_done_i,
    output dma_pkg::copy_rsp_t  rsp_o,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output logic                busy_o
);

    import dma_pkg::*;

    job_cnt_t done_cnt_q;
    logic     head_ready;
    logic     rsp_fire;
    logic     done_take;

    // Writes finish in job order, so any stored completion belongs to the head copy job
    assign head_ready = rsp_job_i.error | (done_cnt_q != '0);

    // --------------------
    // Response channel
    // --------------------
    assign rsp_valid_o     = rsp_job_valid_i & head_ready;
    assign rsp_o           = '{error: rsp_job_i.error, last: rsp_job_i.last};
    assign rsp_fire        = rsp_valid_o & rsp_ready_i;
    assign rsp_job_ready_o = rsp_fire;

    // Rejected jobs never produced a completion
    assign done_take = rsp_fire & ~rsp_job_i.error;

    // Completions waiting for their response, bounded by the queue depth
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            done_cnt_q <= '0;
        end else begin
            done_cnt_q <= done_cnt_q + job_cnt_t'(job_done_i) - job_cnt_t'(done_take);
        end
    end

    assign busy_o = rsp_job_valid_i | (done_cnt_q != '0);

endmodule

/* hdl/dma_write_engine.sv */
// Write side: pairs buffered words with destination addresses of the current job
// and flags the completion of each job with a single-cycle pulse
`timescale 1ns/1ps

module dma_write_engine (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  dma_pkg::wr_job_t     job_i,
    input  logic                 job_valid_i,
    output logic                 job_ready_o,
    input  dma_pkg::data_t       buf_data_i,
    input  logic                 buf_valid_i,
    output logic                 buf_ready_o,
    output dma_pkg::mem_wr_req_t wr_req_o,
    output logic                 wr_valid_o,
    input  logic                 wr_ready_i,
    output logic                 job_done_o,
    output logic                 busy_o
);

    import dma_pkg::*;

    engine_state_e state_q;
    addr_w_t       addr_q;
    len_t          remain_q;
    logic          done_q;
    logic          job_take;
    logic          wr_fire;
    logic          last_word;

    assign job_ready_o = state_q == IDLE;
    assign job_take    = job_valid_i & job_ready_o;

    // Buffer head stays put until popped here, so valid holds while stalled
    assign wr_valid_o = (state_q == ACTIVE) & buf_valid_i;
    assign wr_req_o   = '{addr: addr_q, data: buf_data_i};
    assign wr_fire    = wr_valid_o & wr_ready_i;

    // Word leaves the buffer only together with an accepted write
    assign buf_ready_o = wr_fire;
    assign last_word   = remain_q == len_t'(1);

    // --------------------
    // Job FSM
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= IDLE;
            addr_q   <= '0;
            remain_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (job_take) begin
                        addr_q   <= job_i.dst_addr;
                        remain_q <= job_i.length;
                        state_q  <= ACTIVE;
                    end
                end
                ACTIVE: begin
                    if (wr_fire) begin
                        addr_q   <= addr_q + 1'b1;
                        remain_q <= remain_q - 1'b1;
                        if (last_word) begin
                            state_q <= IDLE;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // One pulse per finished job, the cycle after the final write is accepted
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= wr_fire & last_word;
        end
    end

    assign job_done_o = done_q;
    assign busy_o     = (state_q == ACTIVE) | done_q;

endmodule

/* hdl/dma_read_engine.sv */
// Read side: walks source addresses of one job at a time, limited by buffer credit
// Returned words are forwarded straight into the data buffer
`timescale 1ns/1ps

module dma_read_engine (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  dma_pkg::rd_job_t     job_i,
    input  logic                 job_valid_i,
    output logic                 job_ready_o,
    output dma_pkg::mem_rd_req_t rd_req_o,
    output logic                 rd_valid_o,
    input  logic                 rd_ready_i,
    input  dma_pkg::data_t       rd_data_i,
    input  logic                 rd_data_valid_i,
    output dma_pkg::data_t       buf_data_o,
    output logic                 buf_valid_o,
    input  dma_pkg::buf_cnt_t    buf_space_i,
    output logic                 busy_o
);

    import dma_pkg::*;

    engine_state_e state_q;
    addr_w_t       addr_q;
    len_t          remain_q;
    buf_cnt_t      outstanding_q;
    logic          job_take;
    logic          rd_fire;

    assign job_ready_o = state_q == IDLE;
    assign job_take    = job_valid_i & job_ready_o;

    // Credit check: every outstanding read owns one free buffer slot
    // Space only shrinks as returns land, which also drop outstanding, so valid holds
    assign rd_valid_o = (state_q == ACTIVE) && (outstanding_q < buf_space_i);
    assign rd_req_o   = addr_q;
    assign rd_fire    = rd_valid_o & rd_ready_i;

    // --------------------
    // Job FSM
    // --------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= IDLE;
            addr_q   <= '0;
            remain_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (job_take) begin
                        addr_q   <= job_i.src_addr;
                        remain_q <= job_i.length;
                        state_q  <= ACTIVE;
                    end
                end
                ACTIVE: begin
                    if (rd_fire) begin
                        addr_q   <= addr_q + 1'b1;
                        remain_q <= remain_q - 1'b1;
                        // Last word issued
                        if (remain_q == len_t'(1)) begin
                            state_q <= IDLE;
                        end
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Reads in flight, up on issue and down on return
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            outstanding_q <= '0;
        end else begin
            outstanding_q <= outstanding_q + buf_cnt_t'(rd_fire) - buf_cnt_t'(rd_data_valid_i);
        end
    end

    // Returns come in issue order, credit guarantees room
    assign buf_data_o  = rd_data_i;
    assign buf_valid_o = rd_data_valid_i;

    assign busy_o = (state_q == ACTIVE) || (outstanding_q != '0);

endmodule

/* hdl/dma_req_front.sv */
// Request front end: rejects zero-length copies and forks each request
// into read, write and response jobs, all pushed in the same cycle
`timescale 1ns/1ps

module dma_req_front (
    input  logic                clk_i,
    input  logic                rst_i,
    input  dma_pkg::copy_req_t  req_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,
    output dma_pkg::rd_job_t    rd_job_o,
    output logic                rd_job_valid_o,
    input  logic                rd_job_ready_i,
    output dma_pkg::wr_job_t    wr_job_o,
    output logic                wr_job_valid_o,
    input  logic                wr_job_ready_i,
    output dma_pkg::rsp_job_t   rsp_job_o,
    output logic                rsp_job_valid_o,
    input  logic                rsp_job_ready_i,
    output logic                busy_o
);

    logic is_zero;
    logic push;
    logic busy_q;

    assign is_zero = req_i.length == '0;

    // Zero length only needs the response queue, others need all three
    assign req_ready_o = rsp_job_ready_i & (is_zero | (rd_job_ready_i & wr_job_ready_i));
    assign push        = req_valid_i & req_ready_o;

    // --------------------
    // Job fork
    // --------------------
    assign rd_job_o = '{src_addr: req_i.src_addr, length: req_i.length};
    assign wr_job_o = '{dst_addr: req_i.dst_addr, length: req_i.length};
    // Error marks a rejected request, it never touches memory
    assign rsp_job_o = '{error: is_zero, last: req_i.last};

    assign rd_job_valid_o  = push & ~is_zero;
    assign wr_job_valid_o  = push & ~is_zero;
    assign rsp_job_valid_o = push;

    // Busy while a request sits at the input
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
        end else begin
            busy_q <= req_valid_i & ~push;
        end
    end

    assign busy_o = busy_q;

endmodule

/* hdl/dma_job_fifo.sv */
// Circular-buffer FIFO with valid/ready on both sides
// Serves as the job queues and as the word buffer between read and write sides
`timescale 1ns/1ps

module dma_job_fifo #(
    parameter int unsigned WIDTH = 8,
    parameter int unsigned DEPTH = 4
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  logic [WIDTH-1:0]           data_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    output logic [WIDTH-1:0]           data_o,
    output logic                       valid_o,
    input  logic                       ready_i,
    output logic [$clog2(DEPTH+1)-1:0] free_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    // Ready while not full, valid while not empty
    assign ready_o = count_q != CNT_W'(DEPTH);
    assign valid_o = count_q != '0;
    assign data_o  = mem_q[rd_ptr_q];
    assign free_o  = CNT_W'(DEPTH) - count_q;

    assign push = valid_i & ready_o;
    assign pop  = valid_o & ready_i;

    // Storage, no reset needed
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                // Wrap explicitly, DEPTH need not be a power of two
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

/* hdl/dma_pkg.sv */
// Shared widths, vector types and channel structs of the word copy engine
// Imported by every DMA block that needs a channel or state type

package dma_pkg;

    // --------------------
    // Widths and depths
    // --------------------
    localparam int unsigned ADDR_W    = 16;
    localparam int unsigned DATA_W    = 32;
    localparam int unsigned LEN_W     = 8;
    localparam int unsigned JOB_DEPTH = 4;
    localparam int unsigned BUF_DEPTH = 4;
    // Counters must hold the full depth, not just depth-1
    localparam int unsigned BUF_CNT_W = $clog2(BUF_DEPTH + 1);
    localparam int unsigned JOB_CNT_W = $clog2(JOB_DEPTH + 1);

    typedef logic [ADDR_W-1:0]    addr_w_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [LEN_W-1:0]     len_t;
    typedef logic [BUF_CNT_W-1:0] buf_cnt_t;
    typedef logic [JOB_CNT_W-1:0] job_cnt_t;

    // --------------------
    // Channel structs
    // --------------------
    // Incoming copy request, length counted in words
    typedef struct packed {
        addr_w_t src_addr;
        addr_w_t dst_addr;
        len_t    length;
        logic    last;
    } copy_req_t;

    typedef struct packed {
        logic error;
        logic last;
    } copy_rsp_t;

    typedef struct packed {
        addr_w_t src_addr;
        len_t    length;
    } rd_job_t;

    typedef struct packed {
        addr_w_t dst_addr;
        len_t    length;
    } wr_job_t;

    // Kept per request, in request order
    typedef struct packed {
        logic error;
        logic last;
    } rsp_job_t;

    // Read port carries only the word address
    typedef addr_w_t mem_rd_req_t;

    typedef struct packed {
        addr_w_t addr;
        data_t   data;
    } mem_wr_req_t;

    typedef struct packed {
        logic front_busy;
        logic rd_busy;
        logic wr_busy;
        logic rsp_busy;
    } busy_t;

    // Shared by the read and write engines
    typedef enum logic {
        IDLE,
        ACTIVE
    } engine_state_e;

endpackage
